//--- id_stage.f
+incdir+src
src/id_pkg.sv
src/inst_decoder.sv
src/gpr_file.sv
src/operand_bypass.sv
src/branch_unit.sv
src/id_stage.sv
test/tb_id_stage.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_id_stage \
	  -f id_stage.f -Mdir obj_dir -o tb_id_stage
	./obj_dir/tb_id_stage

clean:
	rm -rf obj_dir

//--- test/tb_id_stage.sv
// testbench for the decode stage, directed instructions checked by gated concurrent assertions
module tb_id_stage import id_pkg::*; ();

  logic      i_clk, i_rst_n;
  logic      i_fs_to_ds_valid, o_ds_allowin, i_es_allowin, o_ds_to_es_valid;
  inst_t     i_fs_inst;
  xlen_t     i_fs_pc;
  logic      i_rf_wen, i_es_load_sel;
  gpr_addr_t i_rf_waddr, i_es_rd, i_ms_rd, i_ws_rd, o_es_rd;
  xlen_t     i_rf_wdata, i_es_result, i_ms_result, i_ws_result;
  xlen_t     o_es_rs1data, o_es_rs2data, o_es_imm, o_es_pc, o_br_target;
  alu_src1_t o_es_alu_src1;
  alu_src2_t o_es_alu_src2;
  alu_op_t   o_es_alu_op;
  mem_op_t   o_es_mem_op;
  logic      o_es_gpr_wen, o_es_mem_ren, o_es_mem_wen, o_es_load_sel, o_es_invalid;
  logic      o_br_taken, o_br_stall;

  logic       chk_hs, chk_dec, chk_en, chk_mem, chk_ops, chk_taken, chk_target;
  logic [2:0] exp_hs;                  // {to_es_valid, allowin, br_stall}
  logic [2:0] exp_src;                 // {alu_src1, alu_src2}
  logic [4:0] exp_en;                  // {gpr_wen, mem_ren, mem_wen, load_sel, invalid}
  gpr_addr_t  exp_rd;
  xlen_t      exp_imm, exp_rs1, exp_rs2, exp_target, exp_pc;
  alu_op_t    exp_alu_op;
  mem_op_t    exp_mem_op;
  logic       exp_taken;
  xlen_t      shadow [32];
  integer     seed;

  id_stage i_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  task automatic mismatch(input string name, input xlen_t exp, input xlen_t act);
    $display("** Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
    $display("Test failed");
    $fatal(1, "output check failed");
  endtask

  assert property (@(posedge i_clk)
                   chk_hs |-> {o_ds_to_es_valid, o_ds_allowin, o_br_stall} == exp_hs)
    else mismatch("{o_ds_to_es_valid,o_ds_allowin,o_br_stall}", 64'(exp_hs),
                  64'($sampled({o_ds_to_es_valid, o_ds_allowin, o_br_stall})));
  assert property (@(posedge i_clk) chk_dec |-> o_es_rd == exp_rd)
    else mismatch("o_es_rd", 64'(exp_rd), 64'($sampled(o_es_rd)));
  assert property (@(posedge i_clk) chk_dec |-> o_es_imm == exp_imm)
    else mismatch("o_es_imm", exp_imm, $sampled(o_es_imm));
  assert property (@(posedge i_clk) chk_dec |-> o_es_pc == exp_pc)
    else mismatch("o_es_pc", exp_pc, $sampled(o_es_pc));
  assert property (@(posedge i_clk) chk_dec |-> o_es_alu_op == exp_alu_op)
    else mismatch("o_es_alu_op", 64'(exp_alu_op), 64'($sampled(o_es_alu_op)));
  assert property (@(posedge i_clk) chk_dec |-> {o_es_alu_src1, o_es_alu_src2} == exp_src)
    else mismatch("{o_es_alu_src1,o_es_alu_src2}", 64'(exp_src),
                  64'($sampled({o_es_alu_src1, o_es_alu_src2})));
  assert property (@(posedge i_clk) chk_en |->
                   {o_es_gpr_wen, o_es_mem_ren, o_es_mem_wen, o_es_load_sel, o_es_invalid}
                   == exp_en)
    else mismatch("{o_es_gpr_wen,o_es_mem_ren,o_es_mem_wen,o_es_load_sel,o_es_invalid}",
                  64'(exp_en),
                  64'($sampled({o_es_gpr_wen, o_es_mem_ren, o_es_mem_wen, o_es_load_sel,
                                o_es_invalid})));
  assert property (@(posedge i_clk) chk_mem |-> o_es_mem_op == exp_mem_op)
    else mismatch("o_es_mem_op", 64'(exp_mem_op), 64'($sampled(o_es_mem_op)));
  assert property (@(posedge i_clk) chk_ops |-> o_es_rs1data == exp_rs1)
    else mismatch("o_es_rs1data", exp_rs1, $sampled(o_es_rs1data));
  assert property (@(posedge i_clk) chk_ops |-> o_es_rs2data == exp_rs2)
    else mismatch("o_es_rs2data", exp_rs2, $sampled(o_es_rs2data));
  assert property (@(posedge i_clk) chk_taken |-> o_br_taken == exp_taken)
    else mismatch("o_br_taken", 64'(exp_taken), 64'($sampled(o_br_taken)));
  assert property (@(posedge i_clk) chk_target |-> o_br_target == exp_target)
    else mismatch("o_br_target", exp_target, $sampled(o_br_target));

  function automatic inst_t enc_r(logic [6:0] f7, gpr_addr_t rs2, gpr_addr_t rs1,
                                  logic [2:0] f3, gpr_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic inst_t enc_i(logic [11:0] imm, gpr_addr_t rs1, logic [2:0] f3,
                                  gpr_addr_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t enc_s(logic [11:0] imm, gpr_addr_t rs2, gpr_addr_t rs1,
                                  logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic inst_t enc_b(logic [12:0] imm, gpr_addr_t rs2, gpr_addr_t rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic inst_t enc_u(logic [19:0] imm, gpr_addr_t rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic inst_t enc_j(logic [20:0] imm, gpr_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic step();
    @(posedge i_clk);
    #2;
  endtask

  // flags drop right after the edge that checked them
  task automatic check_cycle();
    step();
    {chk_hs, chk_dec, chk_en, chk_mem, chk_ops, chk_taken, chk_target} = '0;
  endtask

  task automatic timeout_fail(input string what);
    $display("Test failed");
    $fatal(1, "timed out waiting for %s", what);
  endtask

  task automatic wait_allowin();
    int n;
    n = 0;
    do begin
      if (n == 20) timeout_fail("decode to accept an instruction");
      step();
      n++;
    end while (!o_ds_allowin);
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    do begin
      if (n == 20) timeout_fail("decode to release its instruction");
      step();
      n++;
    end while (!o_ds_to_es_valid);
  endtask

  task automatic write_gpr(input gpr_addr_t addr, input xlen_t data);
    i_rf_wen = 1'b1;
    i_rf_waddr = addr;
    i_rf_wdata = data;
    if (addr != '0) shadow[addr] = data;  // x0 keeps zero
    step();
    i_rf_wen = 1'b0;
  endtask

  // one transfer from fetch, instruction sits in decode on return
  task automatic send(input inst_t inst, input xlen_t pc);
    wait_allowin();
    i_fs_to_ds_valid = 1'b1;
    i_fs_inst = inst;
    i_fs_pc = pc;
    exp_pc = pc;
    step();
    i_fs_to_ds_valid = 1'b0;
  endtask

  task automatic expect_hs(input logic [2:0] hs);
    exp_hs = hs;
    chk_hs = 1'b1;
  endtask

  task automatic expect_en(input logic [4:0] en);
    exp_en = en;
    chk_en = 1'b1;
  endtask

  task automatic expect_dec(input gpr_addr_t rd, input xlen_t imm, input alu_op_t op,
                            input logic [2:0] src, input logic [4:0] en);
    exp_rd = rd;
    exp_imm = imm;
    exp_alu_op = op;
    exp_src = src;
    chk_dec = 1'b1;
    expect_en(en);
  endtask

  task automatic expect_mem(input mem_op_t op);
    exp_mem_op = op;
    chk_mem = 1'b1;
  endtask

  task automatic expect_ops(input xlen_t rs1, input xlen_t rs2);
    exp_rs1 = rs1;
    exp_rs2 = rs2;
    chk_ops = 1'b1;
  endtask

  task automatic check_branch(input inst_t inst, input xlen_t pc, input logic taken,
                              input xlen_t target);
    send(inst, pc);
    exp_taken = taken;
    exp_target = target;
    chk_taken = 1'b1;
    chk_target = 1'b1;
    check_cycle();
  endtask

  initial begin
    seed = 11426;
    i_rst_n = 1'b0;
    {i_fs_to_ds_valid, i_es_allowin, i_rf_wen, i_es_load_sel} = '0;
    i_fs_inst = '0;
    i_fs_pc = '0;
    {i_rf_waddr, i_rf_wdata} = '0;
    {i_es_rd, i_ms_rd, i_ws_rd} = '0;
    {i_es_result, i_ms_result, i_ws_result} = '0;
    {chk_hs, chk_dec, chk_en, chk_mem, chk_ops, chk_taken, chk_target} = '0;
    foreach (shadow[i]) shadow[i] = '0;
    repeat (4) @(posedge i_clk);
    #2;
    i_rst_n = 1'b1;
    i_es_allowin = 1'b1;
    expect_hs(3'b010);
    exp_taken = 1'b0;
    chk_taken = 1'b1;
    check_cycle();

    for (int i = 0; i < 5; i++) write_gpr(gpr_addr_t'(i), {$random(seed), $random(seed)});

    send(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd5), 64'h1000);                  // sub x5, x1, x2
    expect_hs(3'b110);
    expect_dec(5'd5, '0, alu_sub, {src1_rs1, src2_rs2}, 5'b10000);
    expect_ops(shadow[1], shadow[2]);
    check_cycle();
    send(enc_i(12'hffb, 5'd0, 3'd0, 5'd6, 7'b0010011), 64'h1004);           // addi x6, x0, -5
    expect_dec(5'd6, 64'hffff_ffff_ffff_fffb, alu_add, {src1_rs1, src2_imm}, 5'b10000);
    check_cycle();
    send(enc_u(20'h80000, 5'd8, 7'b0110111), 64'h1008);                     // lui x8
    expect_dec(5'd8, 64'hffff_ffff_8000_0000, alu_pass_b, {src1_rs1, src2_imm}, 5'b10000);
    check_cycle();
    send(enc_s(12'd12, 5'd2, 5'd1, 3'd2), 64'h100c);                        // sw x2, 12(x1)
    expect_dec(5'd12, 64'd12, alu_add, {src1_rs1, src2_imm}, 5'b00100);      // rd field is imm[4:0]
    expect_mem(mem_w);
    expect_ops(shadow[1], shadow[2]);
    check_cycle();
    send(enc_i(12'hff8, 5'd2, 3'd3, 5'd9, 7'b0000011), 64'h1010);           // ld x9, -8(x2)
    expect_dec(5'd9, 64'hffff_ffff_ffff_fff8, alu_add, {src1_rs1, src2_imm}, 5'b11010);
    expect_mem(mem_d);
    check_cycle();
    send(32'hffff_ffff, 64'h1014);
    expect_en(5'b00001);
    check_cycle();

    // bypass results present but every rd is zero
    i_es_result = {$random(seed), $random(seed)};
    i_ms_result = {$random(seed), $random(seed)};
    i_ws_result = {$random(seed), $random(seed)};
    send(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd7), 64'h1018);                  // add x7, x0, x0
    expect_ops('0, '0);
    check_cycle();

    {i_es_rd, i_ms_rd, i_ws_rd} = {5'd3, 5'd3, 5'd3};
    send(enc_r(7'h00, 5'd4, 5'd3, 3'd0, 5'd10), 64'h101c);                 // add x10, x3, x4
    i_es_allowin = 1'b0;
    i_fs_to_ds_valid = 1'b1;                                               // must not get in
    i_fs_inst = enc_r(7'h20, 5'd1, 5'd1, 3'd0, 5'd13);
    i_fs_pc = 64'h1020;
    for (int k = 0; k < 4; k++) begin
      expect_hs(3'b100);
      expect_dec(5'd10, '0, alu_add, {src1_rs1, src2_rs2}, 5'b10000);
      expect_ops(k == 0 ? i_es_result : k == 1 ? i_ms_result : k == 2 ? i_ws_result : shadow[3],
                 shadow[4]);
      check_cycle();
      if (k == 0) i_es_rd = '0;
      else if (k == 1) i_ms_rd = '0;
      else i_ws_rd = '0;
    end
    i_fs_to_ds_valid = 1'b0;
    i_es_allowin = 1'b1;
    expect_hs(3'b110);
    check_cycle();

    send(enc_b(13'h010, 5'd1, 5'd1, 3'd0), 64'h100);                       // beq x1, x1, +16
    i_es_rd = 5'd1;
    i_es_load_sel = 1'b1;
    expect_hs(3'b001);
    exp_taken = 1'b1;
    exp_target = 64'h100 + 64'h10;
    {chk_taken, chk_target} = 2'b11;
    check_cycle();
    i_es_allowin = 1'b0;                                                   // hold it once released
    i_es_load_sel = 1'b0;
    wait_valid();
    i_es_rd = '0;
    i_es_allowin = 1'b1;
    expect_hs(3'b110);
    check_cycle();

    write_gpr(5'd11, '1);
    write_gpr(5'd12, 64'd1);
    check_branch(enc_b(13'h020, 5'd12, 5'd11, 3'd0), 64'h200, 1'b0, 64'h200 + 64'h20);  // beq
    check_branch(enc_b(13'h1ff0, 5'd12, 5'd11, 3'd1), 64'h200, 1'b1, 64'h200 - 64'h10); // bne
    check_branch(enc_b(13'h040, 5'd12, 5'd11, 3'd4), 64'h240, 1'b1, 64'h240 + 64'h40);  // blt
    check_branch(enc_b(13'h040, 5'd12, 5'd11, 3'd6), 64'h240, 1'b0, 64'h240 + 64'h40);  // bltu
    check_branch(enc_j(21'h1fffc0, 5'd1), 64'h300, 1'b1, 64'h300 - 64'h40);             // jal
    check_branch(enc_i(12'd4, 5'd12, 3'd0, 5'd0, 7'b1100111), 64'h300, 1'b1, 64'h4);   // jalr, 1 + 4
    $display("Test passed");
    $finish;
  end

endmodule

//--- src/id_stage.sv
// decode stage top, holds the fetched instruction and hands decoded operands on to execute
module id_stage import id_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  // fetch handshake
  input  logic      i_fs_to_ds_valid,
  input  inst_t     i_fs_inst,
  input  xlen_t     i_fs_pc,
  output logic      o_ds_allowin,
  // execute handshake
  input  logic      i_es_allowin,
  output logic      o_ds_to_es_valid,
  // register file write from writeback
  input  logic      i_rf_wen,
  input  gpr_addr_t i_rf_waddr,
  input  xlen_t     i_rf_wdata,
  // bypass
  input  gpr_addr_t i_es_rd,
  input  xlen_t     i_es_result,
  input  logic      i_es_load_sel,
  input  gpr_addr_t i_ms_rd,
  input  xlen_t     i_ms_result,
  input  gpr_addr_t i_ws_rd,
  input  xlen_t     i_ws_result,
  // to execute
  output xlen_t     o_es_rs1data,
  output xlen_t     o_es_rs2data,
  output xlen_t     o_es_imm,
  output xlen_t     o_es_pc,
  output alu_src1_t o_es_alu_src1,
  output alu_src2_t o_es_alu_src2,
  output alu_op_t   o_es_alu_op,
  output gpr_addr_t o_es_rd,
  output logic      o_es_gpr_wen,
  output logic      o_es_mem_ren,
  output logic      o_es_mem_wen,
  output mem_op_t   o_es_mem_op,
  output logic      o_es_load_sel,
  output logic      o_es_invalid,
  // redirect to fetch
  output logic      o_br_taken,
  output xlen_t     o_br_target,
  output logic      o_br_stall
);

  logic      ds_valid;
  logic      ds_ready_go;
  inst_t     ds_inst;
  gpr_addr_t rs1, rs2;
  logic      rs1_used, rs2_used;
  xlen_t     rf_rdata1, rf_rdata2;
  br_func_t  br_func;
  logic      load_stall;
  logic      br_taken;

  assign ds_ready_go      = !load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_inst <= i_fs_inst;
      o_es_pc <= i_fs_pc;
    end
  end

  inst_decoder u_decoder (
    .i_inst (ds_inst), .o_rs1 (rs1), .o_rs2 (rs2), .o_rd (o_es_rd), .o_imm (o_es_imm),
    .o_rs1_used (rs1_used), .o_rs2_used (rs2_used),
    .o_alu_src1 (o_es_alu_src1), .o_alu_src2 (o_es_alu_src2), .o_alu_op (o_es_alu_op),
    .o_br_func (br_func), .o_gpr_wen (o_es_gpr_wen),
    .o_mem_ren (o_es_mem_ren), .o_mem_wen (o_es_mem_wen), .o_mem_op (o_es_mem_op),
    .o_load_sel (o_es_load_sel), .o_invalid (o_es_invalid)
  );

  gpr_file u_gprs (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_raddr1 (rs1), .i_raddr2 (rs2), .o_rdata1 (rf_rdata1), .o_rdata2 (rf_rdata2),
    .i_wen (i_rf_wen), .i_waddr (i_rf_waddr), .i_wdata (i_rf_wdata)
  );

  operand_bypass u_bypass (
    .i_rs1 (rs1), .i_rs2 (rs2), .i_rs1_used (rs1_used), .i_rs2_used (rs2_used),
    .i_rf_rdata1 (rf_rdata1), .i_rf_rdata2 (rf_rdata2),
    .i_es_rd (i_es_rd), .i_es_result (i_es_result), .i_es_load_sel (i_es_load_sel),
    .i_ms_rd (i_ms_rd), .i_ms_result (i_ms_result),
    .i_ws_rd (i_ws_rd), .i_ws_result (i_ws_result),
    .o_rs1data (o_es_rs1data), .o_rs2data (o_es_rs2data), .o_load_stall (load_stall)
  );

  branch_unit u_bru (
    .i_br_func (br_func), .i_alu_src1 (o_es_alu_src1),
    .i_rs1data (o_es_rs1data), .i_rs2data (o_es_rs2data),
    .i_pc (o_es_pc), .i_imm (o_es_imm), .o_taken (br_taken), .o_target (o_br_target)
  );

  assign o_br_taken = ds_valid && br_taken;
  assign o_br_stall = o_br_taken && load_stall; // operands not final, fetch holds

  // a held instruction stays put until execute takes it
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
                   ds_valid && !o_ds_allowin |=> ds_valid && $stable(ds_inst) && $stable(o_es_pc))
    else $error("decode: stage content changed while blocked");

endmodule

//--- src/branch_unit.sv
// branch compare and redirect target for branches, jal and jalr
module branch_unit import id_pkg::*; (
  input  br_func_t  i_br_func,
  input  alu_src1_t i_alu_src1,
  input  xlen_t     i_rs1data,
  input  xlen_t     i_rs2data,
  input  xlen_t     i_pc,
  input  xlen_t     i_imm,
  output logic      o_taken,
  output xlen_t     o_target
);

  logic  eq;
  logic  lt_s;
  logic  lt_u;
  logic  is_jalr;
  xlen_t jalr_sum;

  assign eq   = (i_rs1data == i_rs2data);
  assign lt_s = ($signed(i_rs1data) < $signed(i_rs2data));
  assign lt_u = (i_rs1data < i_rs2data);

  always_comb begin
    case (i_br_func)
      br_beq:  o_taken = eq;
      br_bne:  o_taken = !eq;
      br_blt:  o_taken = lt_s;
      br_bge:  o_taken = !lt_s;
      br_bltu: o_taken = lt_u;
      br_bgeu: o_taken = !lt_u;
      br_jump: o_taken = 1'b1;
      default: o_taken = 1'b0;
    endcase
  end

  // jal uses pc as src1, jalr uses rs1
  assign is_jalr  = (i_br_func == br_jump) && (i_alu_src1 == src1_rs1);
  assign jalr_sum = i_rs1data + i_imm;
  assign o_target = is_jalr ? {jalr_sum[$bits(xlen_t)-1:1], 1'b0} : i_pc + i_imm;

endmodule

//--- src/operand_bypass.sv
// operand forwarding from execute, memory and writeback, plus load-use stall detection
module operand_bypass import id_pkg::*; (
  input  gpr_addr_t i_rs1,
  input  gpr_addr_t i_rs2,
  input  logic      i_rs1_used,
  input  logic      i_rs2_used,
  input  xlen_t     i_rf_rdata1,
  input  xlen_t     i_rf_rdata2,
  // execute
  input  gpr_addr_t i_es_rd,
  input  xlen_t     i_es_result,
  input  logic      i_es_load_sel,
  // memory
  input  gpr_addr_t i_ms_rd,
  input  xlen_t     i_ms_result,
  // writeback
  input  gpr_addr_t i_ws_rd,
  input  xlen_t     i_ws_result,
  output xlen_t     o_rs1data,
  output xlen_t     o_rs2data,
  output logic      o_load_stall
);

  // youngest producer wins, rd of zero never matches
  function automatic xlen_t pick(gpr_addr_t rs, xlen_t rf_data);
    if (i_es_rd != '0 && rs == i_es_rd) return i_es_result;
    if (i_ms_rd != '0 && rs == i_ms_rd) return i_ms_result;
    if (i_ws_rd != '0 && rs == i_ws_rd) return i_ws_result;
    return rf_data;
  endfunction

  logic rs1_hit_es;
  logic rs2_hit_es;

  assign o_rs1data = pick(i_rs1, i_rf_rdata1);
  assign o_rs2data = pick(i_rs2, i_rf_rdata2);

  assign rs1_hit_es = i_rs1_used && (i_rs1 == i_es_rd);
  assign rs2_hit_es = i_rs2_used && (i_rs2 == i_es_rd);

  // load data only exists from mem on, so the forwarded es result is not usable yet
  assign o_load_stall = i_es_load_sel && (i_es_rd != '0) && (rs1_hit_es || rs2_hit_es);

  // a stall only ever holds back an operand taken from execute
  always_comb begin
    assert (!o_load_stall || (rs1_hit_es && o_rs1data == i_es_result)
            || (rs2_hit_es && o_rs2data == i_es_result))
      else $error("bypass: load stall without an operand forwarded from execute");
  end

endmodule

//--- src/gpr_file.sv
// 32 x 64-bit general-purpose register file, two combinational reads and one write at the edge
`include "id_defines.svh"

module gpr_file import id_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  // read ports
  input  gpr_addr_t i_raddr1,
  input  gpr_addr_t i_raddr2,
  output xlen_t     o_rdata1,
  output xlen_t     o_rdata2,
  // write port from writeback
  input  logic      i_wen,
  input  gpr_addr_t i_waddr,
  input  xlen_t     i_wdata
);

  xlen_t regs [`ID_GPR_NUM];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `ID_GPR_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin // x0 stays zero
      regs[i_waddr] <= i_wdata;
    end
  end

  // no write-through, a same-cycle write shows up after the edge
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- src/inst_decoder.sv
// combinational RV64I decoder, turns one instruction into register indexes, immediate and controls
module inst_decoder import id_pkg::*; (
  input  inst_t     i_inst,
  output gpr_addr_t o_rs1,
  output gpr_addr_t o_rs2,
  output gpr_addr_t o_rd,
  output xlen_t     o_imm,
  output logic      o_rs1_used,
  output logic      o_rs2_used,
  output alu_src1_t o_alu_src1,
  output alu_src2_t o_alu_src2,
  output alu_op_t   o_alu_op,
  output br_func_t  o_br_func,
  output logic      o_gpr_wen,
  output logic      o_mem_ren,
  output logic      o_mem_wen,
  output mem_op_t   o_mem_op,
  output logic      o_load_sel,
  output logic      o_invalid
);

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  // sign extended by the size casts
  assign imm_i = xlen_t'($signed(i_inst[31:20]));
  assign imm_s = xlen_t'($signed({i_inst[31:25], i_inst[11:7]}));
  assign imm_b = xlen_t'($signed({i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0}));
  assign imm_u = xlen_t'($signed({i_inst[31:12], 12'b0}));
  assign imm_j = xlen_t'($signed({i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0}));

  // shared by op-imm and op; alt picks sub / sra
  function automatic alu_op_t alu_op_of(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_comb begin
    o_imm = '0; o_rs1_used = 1'b0; o_rs2_used = 1'b0;
    o_alu_src1 = src1_rs1;
    o_alu_src2 = src2_rs2;
    o_alu_op = alu_add;
    o_br_func = br_none;
    o_gpr_wen = 1'b0; o_mem_ren = 1'b0; o_mem_wen = 1'b0;
    o_mem_op = mem_op_t'(funct3 & 3'b011); // width only, stores reuse it
    o_invalid = 1'b0;
    case (opcode)
      op_lui: begin
        o_imm = imm_u; o_alu_src2 = src2_imm; o_alu_op = alu_pass_b; o_gpr_wen = 1'b1;
      end
      op_auipc: begin
        o_imm = imm_u; o_alu_src1 = src1_pc; o_alu_src2 = src2_imm; o_gpr_wen = 1'b1;
      end
      op_jal: begin
        o_imm = imm_j; o_alu_src1 = src1_pc; o_alu_src2 = src2_four;
        o_br_func = br_jump; o_gpr_wen = 1'b1;
      end
      op_jalr: begin // src1 = rs1 marks jalr for the branch unit, link is pc + 4 in execute
        o_imm = imm_i; o_rs1_used = 1'b1; o_alu_src2 = src2_four;
        o_br_func = br_jump; o_gpr_wen = 1'b1;
        o_invalid = (funct3 != 3'b000);
      end
      op_branch: begin
        o_imm = imm_b; o_rs1_used = 1'b1; o_rs2_used = 1'b1; o_alu_op = alu_sub;
        case (funct3)
          3'b000:  o_br_func = br_beq;
          3'b001:  o_br_func = br_bne;
          3'b100:  o_br_func = br_blt;
          3'b101:  o_br_func = br_bge;
          3'b110:  o_br_func = br_bltu;
          3'b111:  o_br_func = br_bgeu;
          default: o_invalid = 1'b1;
        endcase
      end
      op_load: begin
        o_imm = imm_i; o_rs1_used = 1'b1; o_alu_src2 = src2_imm;
        o_gpr_wen = 1'b1; o_mem_ren = 1'b1;
        o_mem_op = mem_op_t'(funct3);
        o_invalid = (funct3 == 3'b111);
      end
      op_store: begin
        o_imm = imm_s; o_rs1_used = 1'b1; o_rs2_used = 1'b1; o_alu_src2 = src2_imm;
        o_mem_wen = 1'b1;
        o_invalid = funct3[2];             // sb..sd only
      end
      op_imm: begin
        o_imm = imm_i; o_rs1_used = 1'b1; o_alu_src2 = src2_imm; o_gpr_wen = 1'b1;
        o_alu_op = alu_op_of(funct3, funct3 == 3'b101 && i_inst[30]);
        // 6-bit shamt, upper bits fixed
        if (funct3 == 3'b001) o_invalid = (i_inst[31:26] != 6'b0);
        if (funct3 == 3'b101) o_invalid = ({i_inst[31], i_inst[29:26]} != 5'b0);
      end
      op_reg: begin
        o_rs1_used = 1'b1; o_rs2_used = 1'b1; o_gpr_wen = 1'b1;
        if (funct7 == 7'b0000000) o_alu_op = alu_op_of(funct3, 1'b0);
        else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))
          o_alu_op = alu_op_of(funct3, 1'b1);
        else o_invalid = 1'b1;
      end
      default: o_invalid = 1'b1;
    endcase
    if (o_invalid) begin
      o_gpr_wen = 1'b0; o_mem_ren = 1'b0; o_mem_wen = 1'b0;
      o_br_func = br_none; o_rs1_used = 1'b0; o_rs2_used = 1'b0;
    end
    o_load_sel = o_mem_ren;
    assert (!(o_mem_ren && o_mem_wen)) else $error("decoder: load and store enabled together");
  end

endmodule

//--- src/id_pkg.sv
// shared data and control types of the decode stage, imported with id_pkg::* in module headers
`include "id_defines.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0]        xlen_t;
  typedef logic [`ID_INST_WD-1:0]     inst_t;
  typedef logic [`ID_GPR_ADDR_WD-1:0] gpr_addr_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and,
    alu_pass_b                                  // lui result
  } alu_op_t;

  typedef enum logic {src1_rs1, src1_pc} alu_src1_t;

  typedef enum logic [1:0] {src2_rs2, src2_imm, src2_four} alu_src2_t;

  typedef enum logic [2:0] {
    br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_jump
  } br_func_t;

  // values follow load/store funct3
  typedef enum logic [2:0] {
    mem_b = 3'd0, mem_h = 3'd1, mem_w = 3'd2, mem_d = 3'd3,
    mem_bu = 3'd4, mem_hu = 3'd5, mem_wu = 3'd6
  } mem_op_t;

endpackage

//--- src/id_defines.svh
// width and size macros for the decode stage, pulled in with `include wherever a macro is used
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// data path and pc width
`define ID_XLEN         64

// fetched instruction word
`define ID_INST_WD      32

// general-purpose register file
`define ID_GPR_ADDR_WD  5
`define ID_GPR_NUM      32

`endif
